/* Bender.yml */
package:
  name: mips_dual_core

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/fetch_unit.sv
      - logic/decoder.sv
      - logic/register_file.sv
      - logic/issue_stage.sv
      - logic/alu.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/mips_dual_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mips_dual_core.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_t op_i,
    input  isa_pkg::word_t   a_i,
    input  isa_pkg::word_t   b_i,
    output isa_pkg::word_t   y_o
);

    import isa_pkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_SLT: y_o = word_t'($signed(a_i) < $signed(b_i));
            // shift amount comes in on a
            ALU_SLL: y_o = b_i << a_i[4:0];
            ALU_LUI: y_o = b_i;
            default: y_o = '0;
        endcase
    end

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  isa_pkg::word_t      inst_i,
    output pipe_pkg::dec_ctrl_t ctrl_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t     op;
    funct_t      funct;
    logic [15:0] imm16;
    logic        known;

    assign op    = inst_i[31:26];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.rs        = inst_i[25:21];
        ctrl_o.rt        = inst_i[20:16];
        ctrl_o.shamt     = inst_i[10:6];
        ctrl_o.imm       = {{16{imm16[15]}}, imm16};
        ctrl_o.reg_wen   = 1'b1;
        ctrl_o.reg_waddr = inst_i[15:11];
        known            = 1'b1;
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_XOR:  ctrl_o.alu_op = ALU_XOR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl_o.alu_op      = ALU_SLL;
                        ctrl_o.src_a_shamt = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.reg_waddr = ctrl_o.rt;
            end
            OP_ORI: begin
                ctrl_o.alu_op    = ALU_OR;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.imm       = {16'h0000, imm16};
                ctrl_o.reg_waddr = ctrl_o.rt;
            end
            OP_LUI: begin
                ctrl_o.alu_op    = ALU_LUI;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.imm       = {imm16, 16'h0000};
                ctrl_o.reg_waddr = ctrl_o.rt;
            end
            OP_SW: begin
                // address from the ALU, rt is the store data
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.store     = 1'b1;
                ctrl_o.reg_wen   = 1'b0;
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            ctrl_o = '0;
        end
        if (ctrl_o.reg_waddr == '0) begin
            ctrl_o.reg_wen = 1'b0;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  pipe_pkg::exec_in_t      master_i,
    input  pipe_pkg::exec_in_t      slave_i,
    output pipe_pkg::result_t [1:0] ex_fwd_o,
    output pipe_pkg::result_t [1:0] ex_result_o,
    output pipe_pkg::store_req_t    store_o,
    output logic                    store_valid_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    exec_in_t [1:0] pipe_in;
    word_t [1:0]    src_a;
    word_t [1:0]    src_b;
    word_t [1:0]    alu_y;

    assign pipe_in = {slave_i, master_i};

    for (genvar i = 0; i < 2; i++) begin : g_pipe
        assign src_a[i] = pipe_in[i].src_a_shamt ? word_t'(pipe_in[i].shamt)
                                                 : pipe_in[i].rs_value;
        assign src_b[i] = pipe_in[i].src_b_imm ? pipe_in[i].imm : pipe_in[i].rt_value;

        alu u_alu (
            .op_i (pipe_in[i].alu_op),
            .a_i  (src_a[i]),
            .b_i  (src_b[i]),
            .y_o  (alu_y[i])
        );

        // execute-stage bypass, straight from the ALU
        assign ex_fwd_o[i] = '{wen: pipe_in[i].reg_wen,
                               waddr: pipe_in[i].reg_waddr,
                               wdata: alu_y[i]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_result_o   <= '0;
            store_valid_o <= 1'b0;
        end else begin
            ex_result_o   <= ex_fwd_o;
            store_valid_o <= master_i.store;
        end
    end

    // only the master pipe stores
    always_ff @(posedge clk) begin
        store_o <= '{addr: alu_y[0], data: master_i.rt_value};
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int unsigned    QUEUE_DEPTH = 8,
    parameter isa_pkg::word_t RESET_PC    = 32'hbfc00000
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         inst_data_ok_i,
    input  logic                         inst_data_ok1_i,
    input  logic                         inst_data_ok2_i,
    input  isa_pkg::word_t               inst_rdata1_i,
    input  isa_pkg::word_t               inst_rdata2_i,
    input  logic [1:0]                   pop_count_i,
    output logic                         inst_sram_en_o,
    output isa_pkg::word_t               F_pc_o,
    output pipe_pkg::fetch_entry_t [1:0] head_o,
    output logic [1:0]                   count_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   level_t;

    fetch_entry_t queue_q [QUEUE_DEPTH];
    ptr_t         rd_ptr_q;
    ptr_t         rd_next;
    ptr_t         wr_ptr_q;
    ptr_t         wr_next;
    level_t       level_q;
    level_t       level_d;
    word_t        pc_q;
    logic         push1;
    logic         push2;

    // word 2 never comes without word 1
    assign push1 = inst_data_ok_i & inst_data_ok1_i;
    assign push2 = inst_data_ok_i & inst_data_ok2_i;

    assign rd_next = rd_ptr_q + ptr_t'(1);
    assign wr_next = wr_ptr_q + ptr_t'(1);
    assign level_d = level_q + level_t'(push1) + level_t'(push2) - level_t'(pop_count_i);

    always_ff @(posedge clk) begin
        if (push1) begin
            queue_q[wr_ptr_q] <= '{pc: pc_q, inst: inst_rdata1_i};
        end
        if (push2) begin
            queue_q[wr_next] <= '{pc: pc_q + 32'd4, inst: inst_rdata2_i};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q           <= RESET_PC;
            rd_ptr_q       <= '0;
            wr_ptr_q       <= '0;
            level_q        <= '0;
            inst_sram_en_o <= 1'b0;
        end else begin
            pc_q     <= pc_q + (push2 ? 32'd8 : (push1 ? 32'd4 : 32'd0));
            rd_ptr_q <= rd_ptr_q + ptr_t'(pop_count_i);
            wr_ptr_q <= wr_ptr_q + ptr_t'(push1) + ptr_t'(push2);
            level_q  <= level_d;
            // request only with room for a full pair
            inst_sram_en_o <= level_d <= level_t'(QUEUE_DEPTH - 2);
        end
    end

    assign F_pc_o    = pc_q;
    assign head_o[0] = queue_q[rd_ptr_q];
    assign head_o[1] = queue_q[rd_next];
    assign count_o   = (level_q >= level_t'(2)) ? 2'd2 : level_q[1:0];

endmodule

/* logic/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_SW      = 6'b101011;

    // SPECIAL function field
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_SLT  = 6'b101010;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

    // sll $0,$0,0
    localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

/* logic/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  pipe_pkg::fetch_entry_t [1:0] head_i,
    input  logic [1:0]                   count_i,
    output logic [1:0]                   pop_count_o,
    output isa_pkg::reg_addr_t [3:0]     rf_raddr_o,
    input  isa_pkg::word_t [3:0]         rf_rdata_i,
    input  pipe_pkg::result_t [1:0]      ex_fwd_i,
    input  pipe_pkg::result_t [1:0]      mem_fwd_i,
    output pipe_pkg::exec_in_t           master_o,
    output pipe_pkg::exec_in_t           slave_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    dec_ctrl_t [1:0] dec;
    word_t [3:0]     operand;
    logic            master_go;
    logic            slave_go;
    logic            slave_dep;

    decoder u_decoder_master (
        .inst_i (head_i[0].inst),
        .ctrl_o (dec[0])
    );

    decoder u_decoder_slave (
        .inst_i (head_i[1].inst),
        .ctrl_o (dec[1])
    );

    // later matches override earlier ones
    function automatic word_t bypass(reg_addr_t addr, word_t rf_value);
        word_t value;
        value = rf_value;
        for (int s = 0; s < 2; s++) begin
            if (mem_fwd_i[s].wen && mem_fwd_i[s].waddr == addr) begin
                value = mem_fwd_i[s].wdata;
            end
        end
        for (int s = 0; s < 2; s++) begin
            if (ex_fwd_i[s].wen && ex_fwd_i[s].waddr == addr) begin
                value = ex_fwd_i[s].wdata;
            end
        end
        return value;
    endfunction

    function automatic exec_in_t to_exec(dec_ctrl_t ctrl, word_t rs_value, word_t rt_value);
        exec_in_t e;
        e.alu_op      = ctrl.alu_op;
        e.src_a_shamt = ctrl.src_a_shamt;
        e.src_b_imm   = ctrl.src_b_imm;
        e.imm         = ctrl.imm;
        e.shamt       = ctrl.shamt;
        e.reg_wen     = ctrl.reg_wen;
        e.reg_waddr   = ctrl.reg_waddr;
        e.store       = ctrl.store;
        e.rs_value    = rs_value;
        e.rt_value    = rt_value;
        return e;
    endfunction

    // master rs, master rt, slave rs, slave rt
    assign rf_raddr_o = {dec[1].rt, dec[1].rs, dec[0].rt, dec[0].rs};

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            operand[p] = bypass(rf_raddr_o[p], rf_rdata_i[p]);
        end
    end

    assign master_go = count_i != 2'd0;
    // slave may not read what the master writes
    assign slave_dep = dec[0].reg_wen &&
                       ((!dec[1].src_a_shamt && dec[1].rs == dec[0].reg_waddr) ||
                        (!dec[1].src_b_imm && dec[1].rt == dec[0].reg_waddr));
    assign slave_go    = (count_i == 2'd2) && !dec[1].store && !slave_dep;
    assign pop_count_o = slave_go ? 2'd2 : {1'b0, master_go};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            master_o <= EXEC_NOP;
            slave_o  <= EXEC_NOP;
        end else begin
            master_o <= master_go ? to_exec(dec[0], operand[0], operand[1]) : EXEC_NOP;
            slave_o  <= slave_go ? to_exec(dec[1], operand[2], operand[3]) : EXEC_NOP;
        end
    end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  pipe_pkg::result_t [1:0] ex_result_i,
    input  pipe_pkg::store_req_t    store_i,
    input  logic                    store_valid_i,
    output pipe_pkg::result_t [1:0] mem_result_o,
    output pipe_pkg::result_t [1:0] wb_result_o,
    output logic                    data_sram_en_o,
    output logic [3:0]              data_sram_wen_o,
    output isa_pkg::word_t          data_sram_addr_o,
    output isa_pkg::word_t          data_sram_wdata_o
);

    // word stores only, all byte lanes
    assign data_sram_en_o    = store_valid_i;
    assign data_sram_wen_o   = {4{store_valid_i}};
    assign data_sram_addr_o  = store_i.addr;
    assign data_sram_wdata_o = store_i.data;

    // results sitting in memory, offered for bypass
    assign mem_result_o = ex_result_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_result_o <= '0;
        end else begin
            wb_result_o <= ex_result_i;
        end
    end

endmodule

/* logic/mips_dual_core.sv */
`timescale 1ns/1ps

module mips_dual_core #(
    parameter int unsigned    QUEUE_DEPTH = 8,
    parameter isa_pkg::word_t RESET_PC    = 32'hbfc00000
) (
    input  logic           clk,
    input  logic           rst_n_i,
    output logic           inst_sram_en_o,
    output isa_pkg::word_t F_pc_o,
    input  logic           inst_data_ok_i,
    input  logic           inst_data_ok1_i,
    input  logic           inst_data_ok2_i,
    input  isa_pkg::word_t inst_rdata1_i,
    input  isa_pkg::word_t inst_rdata2_i,
    output logic           data_sram_en_o,
    output logic [3:0]     data_sram_wen_o,
    output isa_pkg::word_t data_sram_addr_o,
    output isa_pkg::word_t data_sram_wdata_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_entry_t [1:0] head;
    logic [1:0]         head_count;
    logic [1:0]         pop_count;
    reg_addr_t [3:0]    rf_raddr;
    word_t [3:0]        rf_rdata;
    exec_in_t           master_ex;
    exec_in_t           slave_ex;
    result_t [1:0]      ex_fwd;
    result_t [1:0]      ex_result;
    result_t [1:0]      mem_fwd;
    result_t [1:0]      wb_result;
    store_req_t         store;
    logic               store_valid;

    fetch_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_fetch_unit (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_data_ok_i  (inst_data_ok_i),
        .inst_data_ok1_i (inst_data_ok1_i),
        .inst_data_ok2_i (inst_data_ok2_i),
        .inst_rdata1_i   (inst_rdata1_i),
        .inst_rdata2_i   (inst_rdata2_i),
        .pop_count_i     (pop_count),
        .inst_sram_en_o  (inst_sram_en_o),
        .F_pc_o          (F_pc_o),
        .head_o          (head),
        .count_o         (head_count)
    );

    issue_stage u_issue_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .head_i      (head),
        .count_i     (head_count),
        .pop_count_o (pop_count),
        .rf_raddr_o  (rf_raddr),
        .rf_rdata_i  (rf_rdata),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .master_o    (master_ex),
        .slave_o     (slave_ex)
    );

    register_file u_register_file (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .raddr_i     (rf_raddr),
        .rdata_o     (rf_rdata),
        .wb_master_i (wb_result[0]),
        .wb_slave_i  (wb_result[1])
    );

    execute_stage u_execute_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .master_i      (master_ex),
        .slave_i       (slave_ex),
        .ex_fwd_o      (ex_fwd),
        .ex_result_o   (ex_result),
        .store_o       (store),
        .store_valid_o (store_valid)
    );

    memory_stage u_memory_stage (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .ex_result_i       (ex_result),
        .store_i           (store),
        .store_valid_i     (store_valid),
        .mem_result_o      (mem_fwd),
        .wb_result_o       (wb_result),
        .data_sram_en_o    (data_sram_en_o),
        .data_sram_wen_o   (data_sram_wen_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wdata_o (data_sram_wdata_o)
    );

endmodule

/* logic/pipe_pkg.sv */
package pipe_pkg;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_entry_t;

    typedef struct packed {
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::alu_op_t   alu_op;
        logic               src_a_shamt;
        logic               src_b_imm;
        isa_pkg::word_t     imm;
        isa_pkg::shamt_t    shamt;
        logic               reg_wen;
        isa_pkg::reg_addr_t reg_waddr;
        logic               store;
    } dec_ctrl_t;

    // operands already resolved by the issue stage
    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        logic               src_a_shamt;
        logic               src_b_imm;
        isa_pkg::word_t     imm;
        isa_pkg::shamt_t    shamt;
        logic               reg_wen;
        isa_pkg::reg_addr_t reg_waddr;
        logic               store;
        isa_pkg::word_t     rs_value;
        isa_pkg::word_t     rt_value;
    } exec_in_t;

    typedef struct packed {
        logic               wen;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } result_t;

    typedef struct packed {
        isa_pkg::word_t addr;
        isa_pkg::word_t data;
    } store_req_t;

    localparam exec_in_t EXEC_NOP = '0;

endpackage

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  isa_pkg::reg_addr_t [3:0] raddr_i,
    output isa_pkg::word_t [3:0]     rdata_o,
    input  pipe_pkg::result_t        wb_master_i,
    input  pipe_pkg::result_t        wb_slave_i
);

    import isa_pkg::*;

    word_t regs_q [32];

    // slave port written last, so it wins
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs_q <= '{default: '0};
        end else begin
            if (wb_master_i.wen) begin
                regs_q[wb_master_i.waddr] <= wb_master_i.wdata;
            end
            if (wb_slave_i.wen) begin
                regs_q[wb_slave_i.waddr] <= wb_slave_i.wdata;
            end
        end
    end

    // write-through, same priority as the write ports
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else if (wb_slave_i.wen && wb_slave_i.waddr == raddr_i[p]) begin
                rdata_o[p] = wb_slave_i.wdata;
            end else if (wb_master_i.wen && wb_master_i.waddr == raddr_i[p]) begin
                rdata_o[p] = wb_master_i.wdata;
            end else begin
                rdata_o[p] = regs_q[raddr_i[p]];
            end
        end
    end

endmodule

/* tb.f */
+incdir+tb
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/register_file.sv
logic/issue_stage.sv
logic/alu.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_dual_core.sv
tb/tb_mips_dual_core.sv

/* tb/tb_ref_model.svh */
word_t program_q [$];
word_t exp_addr_q [$];
word_t exp_data_q [$];

function automatic word_t rtype_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     shamt_t sa, funct_t fn);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic word_t itype_word(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic build_program();
    // operands, r20 is the store base
    program_q.push_back(itype_word(OP_LUI, 0, 1, 16'h1234));
    program_q.push_back(itype_word(OP_ORI, 1, 1, 16'h5678));
    program_q.push_back(itype_word(OP_ADDIU, 0, 2, 16'hfffd));
    program_q.push_back(itype_word(OP_ADDIU, 0, 3, 16'd100));
    program_q.push_back(itype_word(OP_ORI, 0, 20, 16'h1000));
    // independent pairs covering each ALU operation
    program_q.push_back(rtype_word(1, 2, 4, 0, FN_ADDU));
    program_q.push_back(rtype_word(3, 2, 5, 0, FN_SUBU));
    program_q.push_back(rtype_word(1, 3, 6, 0, FN_AND));
    program_q.push_back(rtype_word(2, 3, 9, 0, FN_SLT));
    program_q.push_back(rtype_word(4, 5, 7, 0, FN_OR));
    program_q.push_back(rtype_word(3, 2, 10, 0, FN_SLT));
    program_q.push_back(rtype_word(6, 7, 8, 0, FN_XOR));
    program_q.push_back(rtype_word(0, 3, 11, 5'd4, FN_SLL));
    for (int r = 1; r <= 11; r++) begin
        program_q.push_back(itype_word(OP_SW, 20, reg_addr_t'(r), 16'(4 * r)));
    end
    // r0 must stay zero
    program_q.push_back(itype_word(OP_ADDIU, 0, 0, 16'h0055));
    program_q.push_back(rtype_word(0, 0, 12, 0, FN_ADDU));
    program_q.push_back(itype_word(OP_SW, 20, 0, 16'h0040));
    program_q.push_back(itype_word(OP_SW, 20, 12, 16'h0044));
    // same destination twice, younger value stays
    program_q.push_back(itype_word(OP_ADDIU, 0, 13, 16'd1));
    program_q.push_back(itype_word(OP_ADDIU, 0, 13, 16'd2));
    program_q.push_back(itype_word(OP_SW, 20, 13, 16'h0048));
    // chain at distances 1 to 3
    program_q.push_back(itype_word(OP_ADDIU, 0, 14, 16'd7));
    program_q.push_back(itype_word(OP_ADDIU, 14, 14, 16'd1));
    program_q.push_back(rtype_word(14, 14, 15, 0, FN_ADDU));
    program_q.push_back(itype_word(OP_ORI, 0, 16, 16'h00f0));
    program_q.push_back(rtype_word(15, 14, 17, 0, FN_SUBU));
    program_q.push_back(rtype_word(17, 15, 18, 0, FN_XOR));
    program_q.push_back(rtype_word(0, 17, 19, 5'd2, FN_SLL));
    for (int r = 14; r <= 19; r++) begin
        program_q.push_back(itype_word(OP_SW, 20, reg_addr_t'(r), 16'(4 * r)));
    end
    // store base and data both just written
    program_q.push_back(itype_word(OP_ADDIU, 20, 21, 16'h0100));
    program_q.push_back(itype_word(OP_ADDIU, 0, 22, 16'h5a5a));
    program_q.push_back(itype_word(OP_SW, 21, 22, 16'h0000));
    // lw is not kept, so r5 keeps its value
    program_q.push_back(itype_word(6'b100011, 20, 5, 16'h0000));
    program_q.push_back(itype_word(OP_SW, 20, 5, 16'h004c));
endtask

task automatic run_model();
    word_t     regs [32];
    word_t     inst;
    word_t     a;
    word_t     b;
    word_t     sext;
    word_t     result;
    reg_addr_t dest;
    logic      writes;
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    foreach (program_q[i]) begin
        inst   = program_q[i];
        a      = regs[inst[25:21]];
        b      = regs[inst[20:16]];
        sext   = {{16{inst[15]}}, inst[15:0]};
        writes = 1'b1;
        dest   = inst[20:16];
        result = '0;
        case (inst[31:26])
            OP_SPECIAL: begin
                dest = inst[15:11];
                case (inst[5:0])
                    FN_ADDU: result = a + b;
                    FN_SUBU: result = a - b;
                    FN_AND:  result = a & b;
                    FN_OR:   result = a | b;
                    FN_XOR:  result = a ^ b;
                    FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  result = b << inst[10:6];
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: result = a + sext;
            OP_ORI:   result = a | {16'h0000, inst[15:0]};
            OP_LUI:   result = {inst[15:0], 16'h0000};
            OP_SW: begin
                writes = 1'b0;
                exp_addr_q.push_back(a + sext);
                exp_data_q.push_back(b);
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != 5'd0) begin
            regs[dest] = result;
        end
    end
endtask

/* tb/tb_mips_dual_core.sv */
`timescale 1ns/1ps

module tb_mips_dual_core;

    import isa_pkg::*;

    localparam int unsigned QUEUE_DEPTH  = 8;
    localparam word_t       RESET_PC     = 32'hbfc00000;
    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned DRAIN_CYCLES = 20;
    // one request cycle plus up to three wait cycles per word
    localparam int unsigned FETCH_WORST  = 4;
    localparam int unsigned PIPE_DEPTH   = 5;
    localparam int unsigned MARGIN       = 100;

    logic        clk;
    logic        rst_n_i;
    logic        inst_sram_en_o;
    word_t       F_pc_o;
    logic        inst_data_ok_i;
    logic        inst_data_ok1_i;
    logic        inst_data_ok2_i;
    word_t       inst_rdata1_i;
    word_t       inst_rdata2_i;
    logic        data_sram_en_o;
    logic [3:0]  data_sram_wen_o;
    word_t       data_sram_addr_o;
    word_t       data_sram_wdata_o;

    integer      seed;
    int unsigned errors = 0;
    int unsigned store_count = 0;
    word_t       next_pc;
    bit          model_ready = 1'b0;

    `include "tb_ref_model.svh"

    mips_dual_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) dut0 (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_sram_en_o    (inst_sram_en_o),
        .F_pc_o            (F_pc_o),
        .inst_data_ok_i    (inst_data_ok_i),
        .inst_data_ok1_i   (inst_data_ok1_i),
        .inst_data_ok2_i   (inst_data_ok2_i),
        .inst_rdata1_i     (inst_rdata1_i),
        .inst_rdata2_i     (inst_rdata2_i),
        .data_sram_en_o    (data_sram_en_o),
        .data_sram_wen_o   (data_sram_wen_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wdata_o (data_sram_wdata_o)
    );

    function automatic word_t program_word(word_t addr);
        int unsigned idx;
        idx = (addr - RESET_PC) >> 2;
        if (idx < program_q.size()) begin
            return program_q[idx];
        end
        return NOP_WORD;
    endfunction

    task automatic report_counts();
        $display("stores checked %0d of %0d, errors %0d",
                 store_count, exp_addr_q.size(), errors);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    reset_data_idle: assert property (@(posedge clk) !rst_n_i |=> !data_sram_en_o)
        else begin
            errors++;
            $display("Error data_sram_en_o: got %h, expected 0", $sampled(data_sram_en_o));
        end

    reset_fetch_idle: assert property (@(posedge clk) !rst_n_i |=> !inst_sram_en_o)
        else begin
            errors++;
            $display("Error inst_sram_en_o: got %h, expected 0", $sampled(inst_sram_en_o));
        end

    reset_pc: assert property (@(posedge clk) !rst_n_i |=> F_pc_o == RESET_PC)
        else begin
            errors++;
            $display("Error F_pc_o: got %h, expected %h", $sampled(F_pc_o), RESET_PC);
        end

    store_full_word: assert property (@(posedge clk) disable iff (!rst_n_i)
                                      data_sram_en_o |-> data_sram_wen_o == 4'hf)
        else begin
            errors++;
            $display("Error data_sram_wen_o: got %h, expected f", $sampled(data_sram_wen_o));
        end

    // instruction SRAM with random latency and partial answers
    initial begin : responder
        int unsigned wait_cycles;
        logic        single;
        inst_data_ok_i  = 1'b0;
        inst_data_ok1_i = 1'b0;
        inst_data_ok2_i = 1'b0;
        inst_rdata1_i   = '0;
        inst_rdata2_i   = '0;
        seed            = 32'h3af7;
        next_pc         = RESET_PC;
        forever begin
            @(negedge clk);
            inst_data_ok_i  = 1'b0;
            inst_data_ok1_i = 1'b0;
            inst_data_ok2_i = 1'b0;
            if (rst_n_i && inst_sram_en_o) begin
                wait_cycles = $unsigned($random(seed)) % 4;
                single      = ($random(seed) & 3) == 0;
                repeat (wait_cycles) @(negedge clk);
                assert (F_pc_o == next_pc) else begin
                    errors++;
                    $display("Error F_pc_o: got %h, expected %h", F_pc_o, next_pc);
                end
                inst_rdata1_i   = program_word(F_pc_o);
                inst_rdata2_i   = single ? NOP_WORD : program_word(F_pc_o + 32'd4);
                inst_data_ok_i  = 1'b1;
                inst_data_ok1_i = 1'b1;
                inst_data_ok2_i = !single;
                next_pc         = next_pc + (single ? 32'd4 : 32'd8);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n_i && data_sram_en_o) begin
            if (store_count < exp_addr_q.size()) begin
                assert (data_sram_addr_o == exp_addr_q[store_count]) else begin
                    errors++;
                    $display("Error data_sram_addr_o: got %h, expected %h",
                             data_sram_addr_o, exp_addr_q[store_count]);
                end
                assert (data_sram_wdata_o == exp_data_q[store_count]) else begin
                    errors++;
                    $display("Error data_sram_wdata_o: got %h, expected %h",
                             data_sram_wdata_o, exp_data_q[store_count]);
                end
            end else begin
                errors++;
                $display("store to address %h came after all expected stores were seen",
                         data_sram_addr_o);
            end
            store_count++;
        end
    end

    initial begin : watchdog
        int unsigned limit;
        wait (model_ready);
        limit = program_q.size() * FETCH_WORST + PIPE_DEPTH + RESET_CYCLES
                + DRAIN_CYCLES + MARGIN;
        repeat (limit) @(posedge clk);
        errors++;
        $display("run did not finish within %0d cycles", limit);
        report_counts();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        rst_n_i = 1'b0;
        build_program();
        run_model();
        model_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        wait (store_count >= exp_addr_q.size());
        // catch any stray store after the last one
        repeat (DRAIN_CYCLES) @(negedge clk);
        assert (store_count == exp_addr_q.size()) else begin
            errors++;
            $display("Error store count: got %h, expected %h", store_count, exp_addr_q.size());
        end
        report_counts();
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
